//--- common/rgmii_pkg.sv
package rgmii_pkg;

    ////////////////////
    // Word and CRC types
    ////////////////////

    typedef struct packed {
        logic       last;
        logic [7:0] data;
    } byte_word_t;

    typedef logic [31:0] crc_t;

    typedef enum logic [1:0] {
        IDLE,
        PREAMBLE,
        PAYLOAD,
        CHECK
    } parser_state_t;

    ////////////////////
    // Frame constants
    ////////////////////

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hd5;

    // Reflected Ethernet polynomial
    localparam crc_t CRC_POLY    = 32'hedb88320;
    localparam crc_t CRC_INIT    = 32'hffffffff;
    // Left in the register by a good frame and its FCS
    localparam crc_t CRC_RESIDUE = 32'hdebb20e3;

    ////////////////////
    // Sizing
    ////////////////////

    localparam int FRAME_FIFO_DEPTH = 64;
    localparam int TX_FIFO_DEPTH    = 32;
    localparam int SLOT_DEPTH       = 128;
    localparam int SLOT_ADDR_WIDTH  = $clog2(SLOT_DEPTH);
    // Two clocks per byte, so 12 byte times
    localparam int IFG_CYCLES       = 24;
    localparam int IFG_COUNT_WIDTH  = $clog2(IFG_CYCLES + 1);

endpackage

//--- hdl/sync_fifo.sv
module sync_fifo #(
    parameter int DEPTH = 16
)(
    input  logic                  clock,
    input  logic                  arst_n,
    input  rgmii_pkg::byte_word_t write_data,
    input  logic                  write_enable,
    input  logic                  read_enable,
    output rgmii_pkg::byte_word_t read_data,
    output logic                  read_data_valid,
    output logic                  full
);

    import rgmii_pkg::*;

    byte_word_t                 memory [DEPTH];
    logic [$clog2(DEPTH)-1:0]   write_pointer;
    logic [$clog2(DEPTH)-1:0]   read_pointer;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       push;
    logic                       pop;

    assign read_data_valid = (count != '0);
    assign full            = (count == DEPTH);
    // Writes into a full buffer are dropped
    assign push            = write_enable && !full;
    assign pop             = read_enable && read_data_valid;

    // Head word shows before it is popped
    assign read_data = memory[read_pointer];

    always_ff @(posedge clock) begin
        if (push) begin
            memory[write_pointer] <= write_data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            count         <= '0;
        end else begin
            if (push) begin
                write_pointer <= (write_pointer == DEPTH - 1) ? '0 : write_pointer + 1'b1;
            end
            if (pop) begin
                read_pointer <= (read_pointer == DEPTH - 1) ? '0 : read_pointer + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rx/rgmii_byte_packager.sv
module rgmii_byte_packager (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic [3:0]            phy_receive_data,
    input  logic                  phy_receive_data_control,
    output rgmii_pkg::byte_word_t packaged_data,
    output logic                  packaged_data_valid
);

    logic       high_phase;
    logic [3:0] low_nibble;
    logic [7:0] held_byte;
    logic       held_valid;
    logic       byte_done;

    // Second nibble of a pair
    assign byte_done = phy_receive_data_control && high_phase;

    // Held byte leaves when the next one completes, or as last when control drops
    assign packaged_data_valid = held_valid && (byte_done || !phy_receive_data_control);
    assign packaged_data       = {!phy_receive_data_control, held_byte};

    always_ff @(posedge clock) begin
        if (phy_receive_data_control && !high_phase) begin
            low_nibble <= phy_receive_data;
        end
        if (byte_done) begin
            held_byte <= {phy_receive_data, low_nibble};
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            high_phase <= 1'b0;
            held_valid <= 1'b0;
        end else begin
            // An odd trailing nibble is lost here
            high_phase <= phy_receive_data_control && !high_phase;
            if (byte_done) begin
                held_valid <= 1'b1;
            end else if (!phy_receive_data_control) begin
                held_valid <= 1'b0;
            end
        end
    end

endmodule

//--- rx/fcs_crc32.sv
module fcs_crc32 (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       crc_clear,
    input  logic [7:0] crc_byte,
    input  logic       crc_enable,
    output logic       crc_match
);

    import rgmii_pkg::*;

    crc_t crc_register;

    // One byte through the reflected polynomial, LSB first
    function automatic crc_t crc_next(input crc_t crc, input logic [7:0] value);
        crc_t result;
        int   i;
        result = crc ^ {24'h000000, value};
        for (i = 0; i < 8; i++) begin
            if (result[0]) begin
                result = (result >> 1) ^ CRC_POLY;
            end else begin
                result = result >> 1;
            end
        end
        return result;
    endfunction

    // FCS bytes run through the register too, leaving the fixed residue
    assign crc_match = (crc_register == CRC_RESIDUE);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            crc_register <= CRC_INIT;
        end else if (crc_clear) begin
            crc_register <= CRC_INIT;
        end else if (crc_enable) begin
            crc_register <= crc_next(crc_register, crc_byte);
        end
    end

endmodule

//--- rx/ethernet_frame_parser.sv
module ethernet_frame_parser (
    input  logic                  clock,
    input  logic                  arst_n,
    input  rgmii_pkg::byte_word_t data,
    input  logic                  data_valid,
    output logic                  data_ready,
    output logic                  crc_clear,
    output logic [7:0]            crc_byte,
    output logic                  crc_enable,
    input  logic                  crc_match,
    output rgmii_pkg::byte_word_t slot_data,
    output logic                  slot_data_valid,
    output logic                  good_frame,
    output logic                  bad_frame
);

    import rgmii_pkg::*;

    parser_state_t state;
    parser_state_t state_next;
    logic          take;
    logic          sfd_seen;

    // CHECK is the only cycle without a read
    assign data_ready = (state != CHECK);
    assign take       = data_ready && data_valid;

    assign sfd_seen = take && (state == PREAMBLE) && !data.last && (data.data == SFD_BYTE);

    assign crc_byte  = data.data;
    assign slot_data = data;

    // Fresh CRC for every frame
    assign crc_clear       = sfd_seen;
    assign crc_enable      = take && (state == PAYLOAD);
    assign slot_data_valid = take && (state == PAYLOAD);

    // crc_match has settled one cycle after the last byte
    assign good_frame = (state == CHECK) && crc_match;
    assign bad_frame  = (state == CHECK) && !crc_match;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (take && !data.last && (data.data == PREAMBLE_BYTE)) begin
                    state_next = PREAMBLE;
                end
            end
            PREAMBLE: begin
                if (sfd_seen) begin
                    state_next = PAYLOAD;
                end else if (take && (data.last || (data.data != PREAMBLE_BYTE))) begin
                    // Broken preamble, nothing reaches the slot
                    state_next = IDLE;
                end
            end
            PAYLOAD: begin
                if (take && data.last) begin
                    state_next = CHECK;
                end
            end
            CHECK: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

//--- rx/receive_slot.sv
module receive_slot (
    input  logic                  clock,
    input  logic                  arst_n,
    input  rgmii_pkg::byte_word_t slot_data,
    input  logic                  slot_data_valid,
    input  logic                  good_frame,
    input  logic                  bad_frame,
    output rgmii_pkg::byte_word_t receive_data,
    output logic                  receive_data_valid,
    input  logic                  receive_data_enable
);

    import rgmii_pkg::*;

    byte_word_t               memory [SLOT_DEPTH];
    logic [SLOT_ADDR_WIDTH:0] write_pointer;
    logic [SLOT_ADDR_WIDTH:0] commit_pointer;
    logic [SLOT_ADDR_WIDTH:0] read_pointer;
    logic [SLOT_ADDR_WIDTH:0] used_words;
    logic                     drop;
    logic                     slot_full;
    logic                     store;
    logic                     pop;

    // Extra pointer bit tells full from empty
    assign used_words = write_pointer - read_pointer;
    assign slot_full  = used_words[SLOT_ADDR_WIDTH];
    assign store      = slot_data_valid && !drop && !slot_full;

    // Only committed words are visible
    assign receive_data_valid = (read_pointer != commit_pointer);
    assign receive_data       = memory[read_pointer[SLOT_ADDR_WIDTH-1:0]];
    assign pop                = receive_data_enable && receive_data_valid;

    always_ff @(posedge clock) begin
        if (store) begin
            memory[write_pointer[SLOT_ADDR_WIDTH-1:0]] <= slot_data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            write_pointer  <= '0;
            commit_pointer <= '0;
            read_pointer   <= '0;
            drop           <= 1'b0;
        end else begin
            if (store) begin
                write_pointer <= write_pointer + 1'b1;
            end
            // Overflow mid-frame, rest of the frame is ignored
            if (slot_data_valid && slot_full) begin
                drop <= 1'b1;
            end
            if (good_frame && !drop) begin
                commit_pointer <= write_pointer;
            end
            // Rollback on a bad or truncated frame
            if (bad_frame || (good_frame && drop)) begin
                write_pointer <= commit_pointer;
            end
            if (good_frame || bad_frame) begin
                drop <= 1'b0;
            end
            if (pop) begin
                read_pointer <= read_pointer + 1'b1;
            end
        end
    end

endmodule

//--- hdl/rgmii_byte_shipper.sv
module rgmii_byte_shipper (
    input  logic                  clock,
    input  logic                  arst_n,
    input  rgmii_pkg::byte_word_t data,
    input  logic                  data_valid,
    output logic                  data_ready,
    output logic [3:0]            phy_transmit_data,
    output logic                  phy_transmit_data_valid
);

    import rgmii_pkg::*;

    logic                       high_phase;
    logic [IFG_COUNT_WIDTH-1:0] gap_count;
    logic                       start_word;

    assign start_word = !high_phase && data_valid && (gap_count == '0);

    // Word is popped with its high nibble
    assign data_ready = high_phase;

    always_ff @(posedge clock) begin
        phy_transmit_data <= high_phase ? data.data[7:4] : data.data[3:0];
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            high_phase              <= 1'b0;
            gap_count               <= '0;
            phy_transmit_data_valid <= 1'b0;
        end else begin
            phy_transmit_data_valid <= start_word || high_phase;
            if (start_word) begin
                high_phase <= 1'b1;
            end else if (high_phase) begin
                high_phase <= 1'b0;
                // Inter-frame gap after the last byte
                if (data.last) begin
                    gap_count <= IFG_COUNT_WIDTH'(IFG_CYCLES);
                end
            end else if (gap_count != '0) begin
                gap_count <= gap_count - 1'b1;
            end
        end
    end

endmodule

//--- hdl/rgmii_port.sv
module rgmii_port (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic [3:0]            phy_receive_data,
    input  logic                  phy_receive_data_control,
    output rgmii_pkg::byte_word_t receive_data,
    output logic                  receive_data_valid,
    input  logic                  receive_data_enable,
    input  rgmii_pkg::byte_word_t transmit_data,
    input  logic                  transmit_data_enable,
    output logic                  transmit_data_ready,
    output logic [3:0]            phy_transmit_data,
    output logic                  phy_transmit_data_valid
);

    import rgmii_pkg::*;

    ////////////////////
    // Receive path
    ////////////////////

    byte_word_t packaged_data;
    logic       packaged_data_valid;
    byte_word_t frame_fifo_read_data;
    logic       frame_fifo_read_data_valid;
    logic       frame_fifo_read_enable;
    logic       crc_clear;
    logic [7:0] crc_byte;
    logic       crc_enable;
    logic       crc_match;
    byte_word_t slot_data;
    logic       slot_data_valid;
    logic       good_frame;
    logic       bad_frame;

    rgmii_byte_packager rgmii_byte_packager (
        .clock                    (clock),
        .arst_n                   (arst_n),
        .phy_receive_data         (phy_receive_data),
        .phy_receive_data_control (phy_receive_data_control),
        .packaged_data            (packaged_data),
        .packaged_data_valid      (packaged_data_valid)
    );

    // Overflow here loses words, the CRC then rejects the frame
    sync_fifo #(
        .DEPTH (FRAME_FIFO_DEPTH)
    ) frame_fifo (
        .clock           (clock),
        .arst_n          (arst_n),
        .write_data      (packaged_data),
        .write_enable    (packaged_data_valid),
        .read_enable     (frame_fifo_read_enable),
        .read_data       (frame_fifo_read_data),
        .read_data_valid (frame_fifo_read_data_valid),
        .full            ()
    );

    ethernet_frame_parser ethernet_frame_parser (
        .clock           (clock),
        .arst_n          (arst_n),
        .data            (frame_fifo_read_data),
        .data_valid      (frame_fifo_read_data_valid),
        .data_ready      (frame_fifo_read_enable),
        .crc_clear       (crc_clear),
        .crc_byte        (crc_byte),
        .crc_enable      (crc_enable),
        .crc_match       (crc_match),
        .slot_data       (slot_data),
        .slot_data_valid (slot_data_valid),
        .good_frame      (good_frame),
        .bad_frame       (bad_frame)
    );

    fcs_crc32 fcs_crc32 (
        .clock      (clock),
        .arst_n     (arst_n),
        .crc_clear  (crc_clear),
        .crc_byte   (crc_byte),
        .crc_enable (crc_enable),
        .crc_match  (crc_match)
    );

    receive_slot receive_slot (
        .clock               (clock),
        .arst_n              (arst_n),
        .slot_data           (slot_data),
        .slot_data_valid     (slot_data_valid),
        .good_frame          (good_frame),
        .bad_frame           (bad_frame),
        .receive_data        (receive_data),
        .receive_data_valid  (receive_data_valid),
        .receive_data_enable (receive_data_enable)
    );

    ////////////////////
    // Transmit path
    ////////////////////

    byte_word_t transmit_fifo_read_data;
    logic       transmit_fifo_read_data_valid;
    logic       transmit_fifo_read_enable;
    logic       transmit_fifo_full;

    assign transmit_data_ready = !transmit_fifo_full;

    sync_fifo #(
        .DEPTH (TX_FIFO_DEPTH)
    ) transmit_fifo (
        .clock           (clock),
        .arst_n          (arst_n),
        .write_data      (transmit_data),
        .write_enable    (transmit_data_enable),
        .read_enable     (transmit_fifo_read_enable),
        .read_data       (transmit_fifo_read_data),
        .read_data_valid (transmit_fifo_read_data_valid),
        .full            (transmit_fifo_full)
    );

    rgmii_byte_shipper rgmii_byte_shipper (
        .clock                   (clock),
        .arst_n                  (arst_n),
        .data                    (transmit_fifo_read_data),
        .data_valid              (transmit_fifo_read_data_valid),
        .data_ready              (transmit_fifo_read_enable),
        .phy_transmit_data       (phy_transmit_data),
        .phy_transmit_data_valid (phy_transmit_data_valid)
    );

endmodule

//--- sim/rgmii_port_tb.sv
module rgmii_port_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rgmii_pkg::*;

    logic       clock;
    logic       arst_n;
    logic [3:0] phy_receive_data;
    logic       phy_receive_data_control;
    byte_word_t receive_data;
    logic       receive_data_valid;
    logic       receive_data_enable;
    byte_word_t transmit_data;
    logic       transmit_data_enable;
    logic       transmit_data_ready;
    logic [3:0] phy_transmit_data;
    logic       phy_transmit_data_valid;

    logic [31:0] rand_state;
    logic [31:0] stall_state;
    logic        stall_reads;
    byte_word_t  rx_expected [$];
    byte_word_t  tx_expected [$];
    string       current_test;
    int unsigned error_count;
    int unsigned check_count;
    int unsigned tests_run;
    int unsigned tests_failed;
    int unsigned budget_cycles;

    // Transmit monitor state
    logic [3:0]  tx_low_nibble;
    logic        tx_high;
    logic        gap_active;
    int unsigned gap_cycles;

    rgmii_port i_dut (
        .clock                    (clock),
        .arst_n                   (arst_n),
        .phy_receive_data         (phy_receive_data),
        .phy_receive_data_control (phy_receive_data_control),
        .receive_data             (receive_data),
        .receive_data_valid       (receive_data_valid),
        .receive_data_enable      (receive_data_enable),
        .transmit_data            (transmit_data),
        .transmit_data_enable     (transmit_data_enable),
        .transmit_data_ready      (transmit_data_ready),
        .phy_transmit_data        (phy_transmit_data),
        .phy_transmit_data_valid  (phy_transmit_data_valid)
    );

    always begin
        #5 clock = ~clock;
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned random_below(input int unsigned limit);
        rand_state = xorshift(rand_state);
        return rand_state % limit;
    endfunction

    // Reflected CRC-32 worked one data bit at a time
    function automatic logic [31:0] crc32_update(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        feedback;
        int          k;
        c = crc;
        for (k = 0; k < 8; k++) begin
            feedback = c[0] ^ b[k];
            c = c >> 1;
            if (feedback) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

    // Preamble, SFD, payload and FCS sent as nibbles with the low nibble first
    task automatic send_frame(input int unsigned payload_length, input bit corrupt);
        logic [7:0]  frame [$];
        logic [7:0]  value;
        logic [31:0] crc;
        byte_word_t  word;
        int unsigned i;
        int unsigned flip_index;
        frame = {};
        crc = CRC_INIT;
        for (i = 0; i < 7; i++) begin
            frame.push_back(PREAMBLE_BYTE);
        end
        frame.push_back(SFD_BYTE);
        for (i = 0; i < payload_length; i++) begin
            value = 8'(random_below(256));
            crc = crc32_update(crc, value);
            frame.push_back(value);
        end
        crc = ~crc;
        for (i = 0; i < 4; i++) begin
            frame.push_back(crc[8*i +: 8]);
        end
        if (corrupt) begin
            flip_index = 8 + random_below(payload_length);
            frame[flip_index] = frame[flip_index] ^ 8'(1 + random_below(255));
        end
        // Only intact frames that fit the slot come out
        if (!corrupt && (payload_length + 4 <= SLOT_DEPTH)) begin
            for (i = 8; i < frame.size(); i++) begin
                word.data = frame[i];
                word.last = (i == frame.size() - 1);
                rx_expected.push_back(word);
            end
        end
        budget_cycles += frame.size() * 4 + 60;
        for (i = 0; i < frame.size(); i++) begin
            @(posedge clock);
            #1;
            phy_receive_data_control = 1'b1;
            phy_receive_data         = frame[i][3:0];
            @(posedge clock);
            #1;
            phy_receive_data = frame[i][7:4];
        end
        @(posedge clock);
        #1;
        phy_receive_data_control = 1'b0;
        phy_receive_data         = 4'h0;
    endtask

    task automatic write_transmit_frame(input int unsigned length);
        byte_word_t  word;
        int unsigned i;
        budget_cycles += length * 4 + 2 * IFG_CYCLES + 20;
        i = 0;
        while (i < length) begin
            @(posedge clock);
            #1;
            if (transmit_data_ready && (random_below(4) != 0)) begin
                word.data            = 8'(random_below(256));
                word.last            = (i == length - 1);
                transmit_data        = word;
                transmit_data_enable = 1'b1;
                tx_expected.push_back(word);
                i++;
            end else begin
                transmit_data_enable = 1'b0;
            end
        end
        @(posedge clock);
        #1;
        transmit_data_enable = 1'b0;
    endtask

    task automatic wait_receive_drained();
        while (rx_expected.size() != 0) begin
            @(posedge clock);
        end
    endtask

    task automatic report_test(input string name, input int unsigned errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_before);
            tests_failed++;
        end
    endtask

    ////////////////////
    // Monitors
    ////////////////////

    always @(posedge clock) begin
        #1;
        if (stall_reads) begin
            stall_state = xorshift(stall_state);
            receive_data_enable = stall_state[7];
        end else begin
            receive_data_enable = 1'b1;
        end
    end

    always @(negedge clock) begin : receive_monitor
        byte_word_t expected_word;
        if (arst_n && receive_data_valid && receive_data_enable) begin
            check_count++;
            if (rx_expected.size() == 0) begin
                $display("%s: a receive word arrived when none was expected", current_test);
                error_count++;
            end else begin
                expected_word = rx_expected.pop_front();
                if (receive_data !== expected_word) begin
                    $display("mismatch %s: expected %h actual %h", current_test,
                             expected_word, receive_data);
                    error_count++;
                end
            end
        end
    end

    always @(negedge clock) begin : transmit_monitor
        byte_word_t expected_word;
        logic [7:0] shipped;
        if (arst_n) begin
            if (phy_transmit_data_valid) begin
                if (gap_active) begin
                    check_count++;
                    if (gap_cycles < IFG_CYCLES) begin
                        $display("%s: inter-frame gap of %0d cycles is too short",
                                 current_test, gap_cycles);
                        error_count++;
                    end
                    gap_active = 1'b0;
                end
                if (!tx_high) begin
                    tx_low_nibble = phy_transmit_data;
                    tx_high       = 1'b1;
                end else begin
                    tx_high = 1'b0;
                    shipped = {phy_transmit_data, tx_low_nibble};
                    check_count++;
                    if (tx_expected.size() == 0) begin
                        $display("%s: a transmit byte left when none was written", current_test);
                        error_count++;
                    end else begin
                        expected_word = tx_expected.pop_front();
                        if (shipped !== expected_word.data) begin
                            $display("mismatch %s: expected %h actual %h", current_test,
                                     expected_word.data, shipped);
                            error_count++;
                        end
                        if (expected_word.last) begin
                            gap_active = 1'b1;
                            gap_cycles = 0;
                        end
                    end
                end
            end else begin
                if (tx_high) begin
                    $display("%s: high nibble did not follow the low nibble", current_test);
                    error_count++;
                    tx_high = 1'b0;
                end
                if (gap_active) begin
                    gap_cycles++;
                end
            end
        end
    end

    // Budget grows with every frame the tests send
    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles <= budget_cycles) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", budget_cycles);
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////
    // Tests
    ////////////////////

    initial begin
        int unsigned i;
        int unsigned errors_before;
        clock                    = 1'b0;
        arst_n                   = 1'b0;
        phy_receive_data         = 4'h0;
        phy_receive_data_control = 1'b0;
        receive_data_enable      = 1'b1;
        transmit_data            = '0;
        transmit_data_enable     = 1'b0;
        rand_state               = 32'd12;
        stall_state              = 32'd12;
        stall_reads              = 1'b0;
        error_count              = 0;
        check_count              = 0;
        tests_run                = 0;
        tests_failed             = 0;
        budget_cycles            = 3000;
        tx_low_nibble            = 4'h0;
        tx_high                  = 1'b0;
        gap_active               = 1'b0;
        gap_cycles               = 0;

        current_test  = "reset";
        errors_before = error_count;
        repeat (8) @(posedge clock);
        #1;
        arst_n = 1'b1;
        @(negedge clock);
        check_count += 3;
        if (receive_data_valid !== 1'b0) begin
            $display("mismatch %s: expected %h actual %h", current_test, 1'b0, receive_data_valid);
            error_count++;
        end
        if (phy_transmit_data_valid !== 1'b0) begin
            $display("mismatch %s: expected %h actual %h", current_test, 1'b0,
                     phy_transmit_data_valid);
            error_count++;
        end
        if (transmit_data_ready !== 1'b1) begin
            $display("mismatch %s: expected %h actual %h", current_test, 1'b1,
                     transmit_data_ready);
            error_count++;
        end
        report_test(current_test, errors_before);

        current_test  = "good_frames";
        errors_before = error_count;
        for (i = 0; i < 6; i++) begin
            send_frame(8 + random_below(53), 1'b0);
        end
        wait_receive_drained();
        report_test(current_test, errors_before);

        current_test  = "bad_frames";
        errors_before = error_count;
        // First frame always bad, last always good
        for (i = 0; i < 6; i++) begin
            send_frame(8 + random_below(53),
                       (i == 0) || ((i != 5) && (random_below(2) == 0)));
        end
        wait_receive_drained();
        // Quiet stretch so a late bad frame would still be caught
        budget_cycles += 200;
        repeat (100) @(posedge clock);
        report_test(current_test, errors_before);

        current_test  = "read_stalls";
        errors_before = error_count;
        stall_reads   = 1'b1;
        for (i = 0; i < 5; i++) begin
            send_frame(8 + random_below(53), 1'b0);
            wait_receive_drained();
        end
        // Frame longer than the slot is dropped whole
        send_frame(SLOT_DEPTH + 2, 1'b0);
        send_frame(8 + random_below(53), 1'b0);
        wait_receive_drained();
        repeat (50) @(posedge clock);
        stall_reads = 1'b0;
        report_test(current_test, errors_before);

        current_test  = "transmit";
        errors_before = error_count;
        for (i = 0; i < 6; i++) begin
            write_transmit_frame(8 + random_below(53));
        end
        while (tx_expected.size() != 0) begin
            @(posedge clock);
        end
        report_test(current_test, errors_before);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- rgmii_port.f
common/rgmii_pkg.sv
hdl/sync_fifo.sv
rx/rgmii_byte_packager.sv
rx/fcs_crc32.sv
rx/ethernet_frame_parser.sv
rx/receive_slot.sv
hdl/rgmii_byte_shipper.sv
hdl/rgmii_port.sv
sim/rgmii_port_tb.sv
